/* src/sprite_pkg.sv */
package sprite_pkg;

	// Bus and beam widths
	localparam int W_DATA = 32;
	localparam int W_COORD = 10;

	// Narrow depths are zero-extended into a full pixel
	typedef logic [7:0] pix_t;

	// 0..3 select 1, 2, 4 or 8 bits per pixel
	typedef logic [1:0] pixmode_t;

	function automatic logic [2:0] log_pixsize(input pixmode_t mode);
		logic [2:0] lps;
		case (mode)
			2'd0: lps = 3'd0;
			2'd1: lps = 3'd1;
			2'd2: lps = 3'd2;
			default: lps = 3'd3;
		endcase
		return lps;
	endfunction

	// Keeps only the lowest set bit, upper bits unused by narrow callers
	function automatic logic [15:0] lowest_one(input logic [15:0] vec);
		return vec & (~vec + 16'd1);
	endfunction

endpackage

/* src/sprite_agu_if.sv */
`timescale 1ns/1ps

interface sprite_agu_if
	import sprite_pkg::*;
#(
	parameter int N_SPRITE = 4,
	parameter int W_COORD = sprite_pkg::W_COORD
);

	// Unit side, one bit or slice per sprite
	wire  [N_SPRITE-1:0]   chk_req;
	wire  [N_SPRITE-1:0]   fetch_vld;
	wire  [N_SPRITE*5-1:0] fetch_postcount;

	// Address unit side, results go to the granted unit
	logic [N_SPRITE-1:0]   chk_ack;
	logic                  chk_active;
	logic [W_COORD-1:0]    chk_x_count;
	logic [6:0]            chk_seek;
	logic [N_SPRITE-1:0]   fetch_rdy;
	logic [W_DATA-1:0]     fetch_data;

	modport agu (
		input  chk_req, fetch_vld, fetch_postcount,
		output chk_ack, chk_active, chk_x_count, chk_seek, fetch_rdy, fetch_data
	);

	modport unit (
		output chk_req, fetch_vld, fetch_postcount,
		input  chk_ack, chk_active, chk_x_count, chk_seek, fetch_rdy, fetch_data
	);

endinterface

/* src/sprite_agu.sv */
`timescale 1ns/1ps

module sprite_agu
	import sprite_pkg::*;
#(
	parameter int N_SPRITE = 4,
	parameter int W_ADDR = 24,
	parameter logic [W_ADDR-1:0] ADDR_MASK = '1
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [W_COORD-1:0]          beam_x,
	input  logic [W_COORD-1:0]          beam_y,
	input  logic [N_SPRITE*W_COORD-1:0] cfg_pos_x,
	input  logic [N_SPRITE*W_COORD-1:0] cfg_pos_y,
	input  logic [N_SPRITE*8-1:0]       cfg_tile,
	input  logic [23:0]                 cfg_tsbase,
	input  pixmode_t                    cfg_pixmode,
	input  logic                        cfg_tilesize,
	sprite_agu_if.agu                   agu,
	output logic                        bus_vld,
	output logic [W_ADDR-1:0]           bus_addr,
	input  logic                        bus_rdy,
	input  logic [W_DATA-1:0]           bus_data
);

	logic [4:0] tile_size;
	logic [2:0] lps;

	logic [15:0]         chk_pick;
	logic [N_SPRITE-1:0] chk_gnt;
	logic [W_COORD-1:0]  chk_pos_x;
	logic [W_COORD-1:0]  chk_pos_y;
	logic [W_COORD:0]    beam_x_far;
	logic [W_COORD:0]    beam_y_far;
	logic                y_hit;
	logic                x_left_of_r;
	logic                x_right_of_l;
	logic [4:0]          seek_cols;

	logic [15:0]         fetch_pick;
	logic [N_SPRITE-1:0] gnt_comb;
	logic [N_SPRITE-1:0] gnt_q;
	logic [N_SPRITE-1:0] gnt;
	logic [7:0]          sel_tile;
	logic [W_COORD-1:0]  sel_pos_y;
	logic [4:0]          sel_postcount;
	logic [W_COORD-1:0]  row_v;
	logic [4:0]          col_u;
	logic [15:0]         pix_idx;
	logic [18:0]         bit_idx;
	logic [15:0]         byte_off;

	assign tile_size = cfg_tilesize ? 5'd16 : 5'd8;
	assign lps = log_pixsize(cfg_pixmode);

	// Coordinate check for the lowest requester
	assign chk_pick = lowest_one(16'(agu.chk_req));
	assign chk_gnt = chk_pick[N_SPRITE-1:0];

	always_comb begin
		chk_pos_x = '0;
		chk_pos_y = '0;
		for (int k = 0; k < N_SPRITE; k++) begin
			if (chk_gnt[k]) begin
				chk_pos_x |= cfg_pos_x[k*W_COORD +: W_COORD];
				chk_pos_y |= cfg_pos_y[k*W_COORD +: W_COORD];
			end
		end
	end

	assign beam_x_far = beam_x + tile_size;
	assign beam_y_far = beam_y + tile_size;

	assign y_hit = (beam_y < chk_pos_y) && (beam_y_far >= {1'b0, chk_pos_y});
	assign x_left_of_r = beam_x < chk_pos_x;
	assign x_right_of_l = beam_x_far >= {1'b0, chk_pos_x};

	assign agu.chk_ack = chk_gnt;
	assign agu.chk_active = y_hit && x_left_of_r;
	assign agu.chk_x_count = x_left_of_r ? chk_pos_x - beam_x : '0;

	// Beam already inside the sprite, start mid-row
	assign seek_cols = tile_size - agu.chk_x_count[4:0];
	assign agu.chk_seek = x_right_of_l ? 7'(seek_cols) << lps : '0;

	// Fetch grant, held until the bus completes
	assign fetch_pick = lowest_one(16'(agu.fetch_vld));
	assign gnt_comb = fetch_pick[N_SPRITE-1:0];
	assign gnt = |gnt_q ? gnt_q : gnt_comb;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gnt_q <= '0;
		end else if (bus_rdy || !(|gnt_q)) begin
			gnt_q <= gnt_comb & ~agu.fetch_rdy;
		end
	end

	always_comb begin
		sel_tile = '0;
		sel_pos_y = '0;
		sel_postcount = '0;
		for (int k = 0; k < N_SPRITE; k++) begin
			if (gnt[k]) begin
				sel_tile |= cfg_tile[k*8 +: 8];
				sel_pos_y |= cfg_pos_y[k*W_COORD +: W_COORD];
				sel_postcount |= agu.fetch_postcount[k*5 +: 5];
			end
		end
	end

	// Pixel index is tile, row, column
	assign row_v = beam_y - (sel_pos_y - tile_size);
	assign col_u = tile_size - sel_postcount;
	assign pix_idx = cfg_tilesize ? {sel_tile, row_v[3:0], col_u[3:0]} :
		{2'b00, sel_tile, row_v[2:0], col_u[2:0]};
	assign bit_idx = {3'b000, pix_idx} << lps;
	assign byte_off = bit_idx[18:3];

	assign bus_addr = (W_ADDR'({cfg_tsbase, 8'h00}) | W_ADDR'(byte_off)) &
		{{(W_ADDR-2){1'b1}}, 2'b00} & ADDR_MASK;
	assign bus_vld = |gnt;

	assign agu.fetch_rdy = gnt & {N_SPRITE{bus_rdy}};
	// Rows narrower than a word sit in a byte lane
	assign agu.fetch_data = bus_data >> {byte_off[1:0], 3'b000};

endmodule

/* src/sprite_unit.sv */
`timescale 1ns/1ps

module sprite_unit
	import sprite_pkg::*;
#(
	parameter int INDEX = 0
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       line_start,
	input  logic       pix_en,
	input  logic       cfg_tilesize,
	input  pixmode_t   cfg_pixmode,
	sprite_agu_if.unit agu,
	output pix_t       pixel,
	output logic       done
);

	typedef enum logic [1:0] {S_IDLE, S_CHECK, S_FETCH, S_RUN} state_t;

	state_t             state;
	logic [W_COORD-1:0] x_count;
	logic [W_COORD-1:0] x_wait;
	logic [7:0]         bit_ptr;
	logic [4:0]         postcount;
	logic [1:0]         word_ptr;
	logic [127:0]       row_buf;
	logic [127:0]       row_shift;
	logic [7:0]         raw;
	logic [4:0]         tile_size;
	logic [2:0]         lps;
	logic [5:0]         pix_per_word;
	logic [7:0]         row_bits;
	logic [3:0]         depth;

	assign tile_size = cfg_tilesize ? 5'd16 : 5'd8;
	assign lps = log_pixsize(cfg_pixmode);
	assign pix_per_word = 6'd32 >> lps;
	assign row_bits = 8'(tile_size) << lps;
	assign depth = 4'd1 << lps;

	assign agu.chk_req[INDEX] = (state == S_CHECK);
	assign agu.fetch_vld[INDEX] = (state == S_FETCH);
	assign agu.fetch_postcount[INDEX*5 +: 5] = postcount;
	assign done = (state == S_RUN);

	// Pixels to go before the left edge
	assign x_wait = (agu.chk_x_count > W_COORD'(tile_size)) ?
		agu.chk_x_count - W_COORD'(tile_size) : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			x_count <= '0;
			bit_ptr <= '0;
			postcount <= '0;
			word_ptr <= '0;
		end else begin
			case (state)
				S_IDLE, S_RUN: begin
					if (line_start) begin
						state <= S_CHECK;
					end else if (state == S_RUN && pix_en) begin
						if (x_count != '0) begin
							x_count <= x_count - 1'b1;
						end else if (bit_ptr < row_bits) begin
							bit_ptr <= bit_ptr + 8'(depth);
						end
					end
				end
				S_CHECK: begin
					if (agu.chk_ack[INDEX]) begin
						if (!agu.chk_active) begin
							// Parked past the row end, shows nothing
							x_count <= '0;
							bit_ptr <= '1;
							state <= S_RUN;
						end else begin
							x_count <= x_wait;
							bit_ptr <= 8'(agu.chk_seek);
							postcount <= tile_size;
							word_ptr <= '0;
							state <= S_FETCH;
						end
					end
				end
				S_FETCH: begin
					if (agu.fetch_rdy[INDEX]) begin
						word_ptr <= word_ptr + 1'b1;
						if ({1'b0, postcount} <= pix_per_word) begin
							postcount <= '0;
							state <= S_RUN;
						end else begin
							postcount <= postcount - pix_per_word[4:0];
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_FETCH && agu.fetch_rdy[INDEX]) begin
			row_buf[word_ptr*32 +: 32] <= agu.fetch_data;
		end
	end

	assign row_shift = row_buf >> bit_ptr;
	assign raw = row_shift[7:0];

	always_comb begin
		pixel = '0;
		if (state == S_RUN && x_count == '0 && bit_ptr < row_bits) begin
			case (lps)
				3'd0: pixel = {7'b0, raw[0]};
				3'd1: pixel = {6'b0, raw[1:0]};
				3'd2: pixel = {4'b0, raw[3:0]};
				default: pixel = raw;
			endcase
		end
	end

endmodule

/* src/sprite_compositor.sv */
`timescale 1ns/1ps

module sprite_compositor
	import sprite_pkg::*;
#(
	parameter int N_SPRITE = 4
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                pix_en,
	input  pix_t [N_SPRITE-1:0] pixels,
	output pix_t                pixel_out,
	output logic                pixel_hit
);

	logic [N_SPRITE-1:0] opaque;
	logic [15:0]         pick;
	pix_t                winner;

	// Value 0 is transparent
	always_comb begin
		for (int k = 0; k < N_SPRITE; k++) begin
			opaque[k] = |pixels[k];
		end
	end

	assign pick = lowest_one(16'(opaque));

	always_comb begin
		winner = '0;
		for (int k = 0; k < N_SPRITE; k++) begin
			if (pick[k]) begin
				winner |= pixels[k];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pixel_out <= '0;
			pixel_hit <= 1'b0;
		end else if (pix_en) begin
			pixel_out <= winner;
			pixel_hit <= |opaque;
		end else begin
			pixel_hit <= 1'b0;
		end
	end

endmodule

/* src/sprite_engine_top.sv */
`timescale 1ns/1ps

module sprite_engine_top
	import sprite_pkg::*;
#(
	parameter int N_SPRITE = 4,
	parameter int W_ADDR = 24,
	parameter logic [W_ADDR-1:0] ADDR_MASK = '1
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        line_start,
	input  logic                        pix_en,
	input  logic [W_COORD-1:0]          beam_x,
	input  logic [W_COORD-1:0]          beam_y,
	input  logic [N_SPRITE*W_COORD-1:0] cfg_pos_x,
	input  logic [N_SPRITE*W_COORD-1:0] cfg_pos_y,
	input  logic [N_SPRITE*8-1:0]       cfg_tile,
	input  logic [23:0]                 cfg_tsbase,
	input  pixmode_t                    cfg_pixmode,
	input  logic                        cfg_tilesize,
	input  logic                        bus_rdy,
	input  logic [W_DATA-1:0]           bus_data,
	output logic                        line_ready,
	output logic                        bus_vld,
	output logic [W_ADDR-1:0]           bus_addr,
	output pix_t                        pixel_out,
	output logic                        pixel_hit
);

	sprite_agu_if #(.N_SPRITE(N_SPRITE), .W_COORD(W_COORD)) agu_bus ();

	pix_t [N_SPRITE-1:0] unit_pixels;
	logic [N_SPRITE-1:0] unit_done;
	logic                line_busy;
	logic                line_go;

	assign line_ready = &unit_done;
	// Lines start only when ready, or for the first line after reset
	assign line_go = line_start && (line_ready || !line_busy);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			line_busy <= 1'b0;
		end else if (line_go) begin
			line_busy <= 1'b1;
		end else if (line_ready) begin
			line_busy <= 1'b0;
		end
	end

	for (genvar k = 0; k < N_SPRITE; k++) begin : g_unit
		sprite_unit #(
			.INDEX (k)
		) i_sprite_unit (
			.clk          (clk),
			.rst_n        (rst_n),
			.line_start   (line_go),
			.pix_en       (pix_en),
			.cfg_tilesize (cfg_tilesize),
			.cfg_pixmode  (cfg_pixmode),
			.agu          (agu_bus.unit),
			.pixel        (unit_pixels[k]),
			.done         (unit_done[k])
		);
	end

	sprite_agu #(
		.N_SPRITE  (N_SPRITE),
		.W_ADDR    (W_ADDR),
		.ADDR_MASK (ADDR_MASK)
	) i_sprite_agu (
		.clk          (clk),
		.rst_n        (rst_n),
		.beam_x       (beam_x),
		.beam_y       (beam_y),
		.cfg_pos_x    (cfg_pos_x),
		.cfg_pos_y    (cfg_pos_y),
		.cfg_tile     (cfg_tile),
		.cfg_tsbase   (cfg_tsbase),
		.cfg_pixmode  (cfg_pixmode),
		.cfg_tilesize (cfg_tilesize),
		.agu          (agu_bus.agu),
		.bus_vld      (bus_vld),
		.bus_addr     (bus_addr),
		.bus_rdy      (bus_rdy),
		.bus_data     (bus_data)
	);

	sprite_compositor #(
		.N_SPRITE (N_SPRITE)
	) i_sprite_compositor (
		.clk       (clk),
		.rst_n     (rst_n),
		.pix_en    (pix_en),
		.pixels    (unit_pixels),
		.pixel_out (pixel_out),
		.pixel_hit (pixel_hit)
	);

endmodule

/* testbench/tb_tile_mem.sv */
`timescale 1ns/1ps

module tb_tile_mem #(
	parameter int DEPTH = 1024,
	parameter int W_ADDR = 24,
	parameter int MAX_DELAY = 3
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              bus_vld,
	input  logic [W_ADDR-1:0] bus_addr,
	output logic              bus_rdy,
	output logic [31:0]       bus_data
);

	localparam int W_IDX = $clog2(DEPTH);

	logic [31:0] mem [DEPTH];
	int unsigned delay;

	// Scrambled fill so every word differs
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = (32'(i) * 32'h9e37_79b1) ^ (32'(i) << 21) ^ 32'h5a3c_0f96;
		end
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bus_rdy <= 1'b0;
			bus_data <= '0;
			delay <= 0;
		end else if (bus_rdy) begin
			bus_rdy <= 1'b0;
			delay <= $urandom_range(MAX_DELAY, 0);
		end else if (bus_vld) begin
			if (delay == 0) begin
				bus_rdy <= 1'b1;
				bus_data <= mem[bus_addr[2 +: W_IDX]];
			end else begin
				delay <= delay - 1;
			end
		end
	end

endmodule

/* testbench/tb_sprite_engine.sv */
`timescale 1ns/1ps

module tb_sprite_engine
	import sprite_pkg::*;
();

	localparam int N_SPRITE = 4;
	localparam int W_ADDR = 24;
	localparam logic [W_ADDR-1:0] ADDR_MASK = '1;
	localparam int TIMEOUT = 500;

	logic                        clk;
	logic                        rst_n;
	logic                        line_start;
	logic                        pix_en;
	logic [W_COORD-1:0]          beam_x;
	logic [W_COORD-1:0]          beam_y;
	logic [N_SPRITE*W_COORD-1:0] cfg_pos_x;
	logic [N_SPRITE*W_COORD-1:0] cfg_pos_y;
	logic [N_SPRITE*8-1:0]       cfg_tile;
	logic [23:0]                 cfg_tsbase;
	pixmode_t                    cfg_pixmode;
	logic                        cfg_tilesize;
	logic                        bus_rdy;
	logic [W_DATA-1:0]           bus_data;
	logic                        line_ready;
	logic                        bus_vld;
	logic [W_ADDR-1:0]           bus_addr;
	pix_t                        pixel_out;
	logic                        pixel_hit;

	int                value_errors;
	int                other_errors;
	logic              hold_pending;
	logic              read_seen;
	logic [W_ADDR-1:0] hold_addr;
	logic [W_ADDR-1:0] addr_log [$];

	sprite_engine_top #(
		.N_SPRITE  (N_SPRITE),
		.W_ADDR    (W_ADDR),
		.ADDR_MASK (ADDR_MASK)
	) i_sprite_engine_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.line_start   (line_start),
		.pix_en       (pix_en),
		.beam_x       (beam_x),
		.beam_y       (beam_y),
		.cfg_pos_x    (cfg_pos_x),
		.cfg_pos_y    (cfg_pos_y),
		.cfg_tile     (cfg_tile),
		.cfg_tsbase   (cfg_tsbase),
		.cfg_pixmode  (cfg_pixmode),
		.cfg_tilesize (cfg_tilesize),
		.bus_rdy      (bus_rdy),
		.bus_data     (bus_data),
		.line_ready   (line_ready),
		.bus_vld      (bus_vld),
		.bus_addr     (bus_addr),
		.pixel_out    (pixel_out),
		.pixel_hit    (pixel_hit)
	);

	tb_tile_mem #(
		.DEPTH     (1024),
		.W_ADDR    (W_ADDR),
		.MAX_DELAY (3)
	) i_tile_mem (
		.clk      (clk),
		.rst_n    (rst_n),
		.bus_vld  (bus_vld),
		.bus_addr (bus_addr),
		.bus_rdy  (bus_rdy),
		.bus_data (bus_data)
	);

	always #50 clk = ~clk;

	task automatic check_pix(input string name, input pix_t exp, input pix_t act);
		if (exp !== act) begin
			$display("FAILED %s: expected %02h, actual %02h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_addr(input string name, input logic [W_ADDR-1:0] exp,
		input logic [W_ADDR-1:0] act);
		if (exp !== act) begin
			$display("FAILED %s: expected %06h, actual %06h", name, exp, act);
			value_errors++;
		end
	endtask

	// Bit address of one row pixel, index is tile, row, column
	function automatic int pix_bit(input int k, input int col);
		int ts;
		int v;
		ts = cfg_tilesize ? 16 : 8;
		v = int'(beam_y) - (int'(cfg_pos_y[k*W_COORD +: W_COORD]) - ts);
		return ((int'(cfg_tile[k*8 +: 8]) * ts + v) * ts + col) << cfg_pixmode;
	endfunction

	function automatic logic [W_ADDR-1:0] tile_addr(input int k, input int col);
		logic [W_ADDR-1:0] byte_off;
		byte_off = W_ADDR'(pix_bit(k, col) >> 3);
		return (W_ADDR'({cfg_tsbase, 8'h00}) | byte_off) & ~W_ADDR'(3) & ADDR_MASK;
	endfunction

	function automatic pix_t sprite_pixel(input int k, input int x);
		int ts;
		int px;
		int py;
		int by;
		int col;
		logic [W_ADDR-1:0] addr;
		logic [31:0] word;
		ts = cfg_tilesize ? 16 : 8;
		px = int'(cfg_pos_x[k*W_COORD +: W_COORD]);
		py = int'(cfg_pos_y[k*W_COORD +: W_COORD]);
		by = int'(beam_y);
		if (by < py - ts || by >= py || x < px - ts || x >= px) begin
			return 8'h00;
		end
		col = x - (px - ts);
		addr = tile_addr(k, col);
		word = i_tile_mem.mem[addr[11:2]];
		return pix_t'((word >> (pix_bit(k, col) % 32)) & ((32'd1 << (1 << cfg_pixmode)) - 1));
	endfunction

	// Lowest index with an opaque pixel wins
	function automatic pix_t line_pixel(input int x);
		pix_t p;
		for (int k = 0; k < N_SPRITE; k++) begin
			p = sprite_pixel(k, x);
			if (p != 8'h00) begin
				return p;
			end
		end
		return 8'h00;
	endfunction

	task clear_sprites;
		cfg_pos_x <= '0;
		cfg_pos_y <= '0;
		cfg_tile <= '0;
	endtask

	task set_sprite(input int k, input int px, input int py, input int tile);
		cfg_pos_x[k*W_COORD +: W_COORD] <= W_COORD'(px);
		cfg_pos_y[k*W_COORD +: W_COORD] <= W_COORD'(py);
		cfg_tile[k*8 +: 8] <= 8'(tile);
	endtask

	task run_line(input string name, input int bx, input int by, input int n_pix);
		int wait_cycles;
		pix_t exp_pix;
		@(posedge clk);
		beam_x <= W_COORD'(bx);
		beam_y <= W_COORD'(by);
		line_start <= 1'b1;
		read_seen = 1'b0;
		addr_log.delete();
		@(posedge clk);
		line_start <= 1'b0;
		wait_cycles = 0;
		do begin
			@(negedge clk);
			wait_cycles++;
		end while (!line_ready && wait_cycles < TIMEOUT);
		if (!line_ready) begin
			$display("%s: line_ready did not rise within %0d cycles", name, TIMEOUT);
			other_errors++;
		end
		@(posedge clk);
		pix_en <= 1'b1;
		for (int k = 0; k < n_pix; k++) begin
			@(posedge clk);
			if (k == n_pix - 1) begin
				pix_en <= 1'b0;
			end
			@(negedge clk);
			exp_pix = line_pixel(bx + k);
			check_pix($sformatf("%s x=%0d", name, bx + k), exp_pix, pixel_out);
			check_bit($sformatf("%s hit x=%0d", name, bx + k), exp_pix != 8'h00, pixel_hit);
		end
	endtask

	task test_reset_idle;
		@(negedge clk);
		check_bit("reset bus_vld", 1'b0, bus_vld);
		check_bit("reset line_ready", 1'b0, line_ready);
		check_bit("reset pixel_hit", 1'b0, pixel_hit);
		@(posedge clk);
		clear_sprites();
		set_sprite(0, 40, 200, 1);
		set_sprite(1, 60, 300, 2);
		run_line("inactive_line", 0, 20, 64);
		check_bit("inactive_line bus read", 1'b0, read_seen);
	endtask

	task test_single_8x8;
		@(posedge clk);
		cfg_pixmode <= 2'd3;
		cfg_tilesize <= 1'b0;
		clear_sprites();
		set_sprite(0, 50, 30, 1);
		run_line("single_8x8", 30, 25, 40);
		for (int c = 0; c < 8; c += 4) begin
			if (addr_log.size() == 0) begin
				$display("single_8x8: no bus read seen for column %0d", c);
				other_errors++;
			end else begin
				check_addr("single_8x8 addr", tile_addr(0, c), addr_log.pop_front());
			end
		end
	endtask

	task test_depths;
		for (int m = 0; m < 3; m++) begin
			for (int t = 0; t < 2; t++) begin
				@(posedge clk);
				cfg_pixmode <= pixmode_t'(m);
				cfg_tilesize <= t[0];
				clear_sprites();
				set_sprite(0, 40, 40, 2);
				set_sprite(1, 70, 45, 3);
				run_line($sformatf("depth_m%0d_t%0d", m, t), 20, 35, 60);
			end
		end
	endtask

	task test_priority;
		logic [W_ADDR-1:0] a;
		@(posedge clk);
		cfg_pixmode <= 2'd3;
		cfg_tilesize <= 1'b0;
		beam_y <= W_COORD'(46);
		clear_sprites();
		set_sprite(0, 60, 50, 1);
		set_sprite(1, 64, 52, 2);
		@(posedge clk);
		// Punch transparent holes into sprite 0, some over sprite 1
		a = tile_addr(0, 0);
		i_tile_mem.mem[a[11:2]] = i_tile_mem.mem[a[11:2]] & 32'hff00_ff00;
		a = tile_addr(0, 4);
		i_tile_mem.mem[a[11:2]] = i_tile_mem.mem[a[11:2]] & 32'h00ff_00ff;
		run_line("priority", 48, 46, 20);
	endtask

	task test_left_seek;
		@(posedge clk);
		cfg_pixmode <= 2'd2;
		cfg_tilesize <= 1'b1;
		clear_sprites();
		set_sprite(0, 20, 60, 1);
		set_sprite(1, 14, 52, 2);
		run_line("left_seek", 11, 50, 20);
	endtask

	task test_back_pressure;
		for (int n = 0; n < 4; n++) begin
			@(posedge clk);
			cfg_pixmode <= pixmode_t'($urandom_range(3, 0));
			cfg_tilesize <= 1'($urandom_range(1, 0));
			for (int k = 0; k < N_SPRITE; k++) begin
				set_sprite(k, 30 + $urandom_range(40, 0), 45 + $urandom_range(2, 0),
					$urandom_range(3, 0));
			end
			run_line($sformatf("back_pressure_%0d", n), $urandom_range(29, 0), 44, 80);
		end
	endtask

	// Bus monitor, a stalled read keeps its address
	always @(negedge clk) begin
		if (rst_n) begin
			if (hold_pending) begin
				check_bit("bus hold vld", 1'b1, bus_vld);
				check_addr("bus hold addr", hold_addr, bus_addr);
			end
			hold_pending = bus_vld && !bus_rdy;
			hold_addr = bus_addr;
			if (bus_vld) begin
				read_seen = 1'b1;
			end
			if (bus_vld && bus_rdy) begin
				addr_log.push_back(bus_addr);
			end
		end
	end

	initial begin
		void'($urandom(32));
		value_errors = 0;
		other_errors = 0;
		hold_pending = 1'b0;
		read_seen = 1'b0;
		clk = 1'b0;
		rst_n = 1'b0;
		line_start = 1'b0;
		pix_en = 1'b0;
		beam_x = '0;
		beam_y = '0;
		cfg_pos_x = '0;
		cfg_pos_y = '0;
		cfg_tile = '0;
		cfg_tsbase = 24'h000002;
		cfg_pixmode = 2'd3;
		cfg_tilesize = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		test_reset_idle();
		test_single_8x8();
		test_depths();
		test_priority();
		test_left_seek();
		test_back_pressure();
		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* all.f */
src/sprite_pkg.sv
src/sprite_agu_if.sv
src/sprite_agu.sv
src/sprite_unit.sv
src/sprite_compositor.sv
src/sprite_engine_top.sv
testbench/tb_tile_mem.sv
testbench/tb_sprite_engine.sv

/* Bender.yml */
package:
  name: sprite_engine

sources:
  - src/sprite_pkg.sv
  - src/sprite_agu_if.sv
  - src/sprite_agu.sv
  - src/sprite_unit.sv
  - src/sprite_compositor.sv
  - src/sprite_engine_top.sv
  - target: test
    files:
      - testbench/tb_tile_mem.sv
      - testbench/tb_sprite_engine.sv
